// File: verilog/rm_config.svh
`ifndef RM_CONFIG_SVH
`define RM_CONFIG_SVH

// circular buffer geometry
`define RM_WORD_W 128
`define RM_PROC_WORDS 200
`define RM_NUM_PROC 4

// field widths
`define RM_ADR_W 10
`define RM_LEN_W 17
`define RM_Z_W 9

`endif

// File: verilog/rm_pkg.sv
`include "rm_config.svh"

package rm_pkg;

    typedef enum logic
    {
        BG1,
        BG2
    } base_graph_e;

    typedef enum logic [1:0]
    {
        IDLE,
        FETCH,
        SHIFT
    } sel_state_e;

    // wishbone classic master request
    typedef struct packed
    {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`RM_ADR_W-1:0]  adr;
        logic [`RM_WORD_W-1:0] dat;
    } wb_req_t;

    // wishbone classic slave response
    typedef struct packed
    {
        logic                  ack;
        logic [`RM_WORD_W-1:0] dat;
    } wb_rsp_t;

    // one rate-matching job
    typedef struct packed
    {
        base_graph_e          bg;
        logic [`RM_Z_W-1:0]   z;    // lifting factor
        logic [1:0]           rv;
        logic [1:0]           pn;   // harq process
        logic [`RM_LEN_W-1:0] ncb;  // circular buffer length in bits
        logic [`RM_LEN_W-1:0] e;    // output bit count
    } rm_job_t;

endpackage

// File: verilog/buffer_loader.sv
`timescale 1ns/1ps
`include "rm_config.svh"

module buffer_loader
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [`RM_WORD_W-1:0] in_word,
    input  logic [1:0]            in_pn,
    input  logic                  in_first,
    output rm_pkg::wb_req_t       wb,
    input  rm_pkg::wb_rsp_t       rsp
);
    import rm_pkg::*;

    localparam logic [`RM_ADR_W-1:0] PROC_WORDS = `RM_PROC_WORDS;

    logic                  open_q;     // write cycle in flight
    logic [`RM_ADR_W-1:0]  idx;        // word index inside the region
    logic [`RM_ADR_W-1:0]  idx_cur;
    logic [`RM_ADR_W-1:0]  pn_w;
    logic [`RM_ADR_W-1:0]  adr_q;
    logic [`RM_WORD_W-1:0] dat_q;
    logic                  accept;

    assign in_ready = !open_q;
    assign accept   = in_valid && in_ready;
    assign idx_cur  = in_first ? '0 : idx;
    assign pn_w     = in_pn;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            open_q <= 1'b0;
            idx    <= '0;
        end
        else if (accept)
        begin
            open_q <= 1'b1;
            idx    <= idx_cur;
        end
        else if (open_q && rsp.ack)
        begin
            open_q <= 1'b0;
            idx    <= (idx == PROC_WORDS - 1) ? '0 : idx + 1'b1;  // stay inside region
        end
    end

    // payload held for the whole cycle
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            adr_q <= pn_w * PROC_WORDS + idx_cur;
            dat_q <= in_word;
        end
    end

    assign wb.cyc = open_q;
    assign wb.stb = open_q;
    assign wb.we  = 1'b1;
    assign wb.adr = adr_q;
    assign wb.dat = dat_q;

endmodule

// File: verilog/buffer_arbiter.sv
`timescale 1ns/1ps

module buffer_arbiter
(
    input  logic            clk,
    input  logic            rst,
    input  rm_pkg::wb_req_t ld_req,
    output rm_pkg::wb_rsp_t ld_rsp,
    input  rm_pkg::wb_req_t sel_req,
    output rm_pkg::wb_rsp_t sel_rsp,
    output rm_pkg::wb_req_t mem_req,
    input  rm_pkg::wb_rsp_t mem_rsp
);
    import rm_pkg::*;

    logic gnt_ld;
    logic gnt_sel;
    logic held;

    // owner keeps the bus until it drops cyc
    assign held = (gnt_ld && ld_req.cyc) || (gnt_sel && sel_req.cyc);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            gnt_ld  <= 1'b0;
            gnt_sel <= 1'b0;
        end
        else if (!held)
        begin
            gnt_ld  <= ld_req.cyc;                  // loader has priority
            gnt_sel <= !ld_req.cyc && sel_req.cyc;
        end
    end

    always_comb
    begin
        if (gnt_ld)
        begin
            mem_req = ld_req;
        end
        else if (gnt_sel)
        begin
            mem_req = sel_req;
        end
        else
        begin
            mem_req = '0;
        end
    end

    // ack goes only to the owner while read data is shared
    assign ld_rsp.ack  = mem_rsp.ack && gnt_ld;
    assign ld_rsp.dat  = mem_rsp.dat;
    assign sel_rsp.ack = mem_rsp.ack && gnt_sel;
    assign sel_rsp.dat = mem_rsp.dat;

endmodule

// File: verilog/circular_buffer_mem.sv
`timescale 1ns/1ps
`include "rm_config.svh"

module circular_buffer_mem
(
    input  logic            clk,
    input  logic            rst,
    input  rm_pkg::wb_req_t req,
    output rm_pkg::wb_rsp_t rsp
);
    import rm_pkg::*;

    localparam int DEPTH = `RM_NUM_PROC * `RM_PROC_WORDS;

    logic [`RM_WORD_W-1:0] mem [DEPTH];  // all harq regions back to back
    logic                  ack_q;
    logic [`RM_WORD_W-1:0] rd_q;
    logic                  hit;

    // new strobe not yet answered
    assign hit = req.cyc && req.stb && !ack_q;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ack_q <= 1'b0;
        end
        else
        begin
            ack_q <= hit;  // single cycle ack
        end
    end

    always_ff @(posedge clk)
    begin
        if (hit && req.we)
        begin
            mem[req.adr] <= req.dat;
        end
        rd_q <= mem[req.adr];
    end

    assign rsp.ack = ack_q;
    assign rsp.dat = rd_q;

endmodule

// File: verilog/bit_selector.sv
`timescale 1ns/1ps
`include "rm_config.svh"

module bit_selector
(
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  rm_pkg::rm_job_t job,
    output logic            busy,
    output logic            done,
    output logic            out_valid,
    input  logic            out_ready,
    output logic            out_bit,
    output rm_pkg::wb_req_t wb,
    input  rm_pkg::wb_rsp_t rsp
);
    import rm_pkg::*;

    localparam logic [`RM_ADR_W-1:0] PROC_WORDS = `RM_PROC_WORDS;

    sel_state_e            state;
    logic [`RM_LEN_W-1:0]  pos;      // current bit position in the buffer
    logic [`RM_LEN_W-1:0]  cnt;      // bits accepted so far
    logic [1:0]            pn_q;
    logic [`RM_LEN_W-1:0]  ncb_q;
    logic [`RM_LEN_W-1:0]  e_q;
    logic [`RM_WORD_W-1:0] word_q;
    logic                  done_q;

    logic [`RM_LEN_W-1:0]  k0;
    logic [`RM_LEN_W-1:0]  pos_inc;
    logic [`RM_LEN_W-1:0]  cnt_inc;
    logic                  wrap;
    logic                  last;
    logic                  accept;
    logic [`RM_ADR_W-1:0]  pn_w;
    logic [`RM_ADR_W-1:0]  widx;

    // k0 = coefficient x z from the base graph and rv tables
    function automatic logic [`RM_LEN_W-1:0] calc_k0(input base_graph_e bg,
                                                    input logic [`RM_Z_W-1:0] z,
                                                    input logic [1:0] rv);
        logic [`RM_LEN_W-1:0] coef;
        logic [`RM_LEN_W-1:0] z_w;
        z_w = z;
        if (bg == BG1)
        begin
            case (rv)
                2'd0: coef = 17'd0;
                2'd1: coef = 17'd17;
                2'd2: coef = 17'd33;
                default: coef = 17'd56;
            endcase
        end
        else
        begin
            case (rv)
                2'd0: coef = 17'd0;
                2'd1: coef = 17'd13;
                2'd2: coef = 17'd25;
                default: coef = 17'd43;
            endcase
        end
        return coef * z_w;
    endfunction

    assign k0      = calc_k0(job.bg, job.z, job.rv);
    assign pos_inc = pos + 1'b1;
    assign wrap    = (pos_inc == ncb_q);
    assign cnt_inc = cnt + 1'b1;
    assign last    = (cnt_inc == e_q);
    assign accept  = (state == SHIFT) && out_ready;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state  <= IDLE;
            pos    <= '0;
            cnt    <= '0;
            done_q <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        pos   <= k0;
                        cnt   <= '0;
                        state <= FETCH;
                    end
                end
                FETCH:
                begin
                    if (rsp.ack)
                    begin
                        state <= SHIFT;
                    end
                end
                SHIFT:
                begin
                    if (accept)
                    begin
                        cnt <= cnt_inc;
                        pos <= wrap ? '0 : pos_inc;
                        if (last)
                        begin
                            state  <= IDLE;
                            done_q <= 1'b1;
                        end
                        else if (wrap || pos[6:0] == 7'd127)
                        begin
                            state <= FETCH;  // next bit lives in another word
                        end
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && start)
        begin
            pn_q  <= job.pn;
            ncb_q <= job.ncb;
            e_q   <= job.e;
        end
        if (state == FETCH && rsp.ack)
        begin
            word_q <= rsp.dat;
        end
    end

    assign pn_w = pn_q;
    assign widx = pos[`RM_LEN_W-1:7];  // 128 bits per word

    assign wb.cyc = (state == FETCH);
    assign wb.stb = (state == FETCH);
    assign wb.we  = 1'b0;
    assign wb.adr = pn_w * PROC_WORDS + widx;
    assign wb.dat = '0;

    assign busy      = (state != IDLE);
    assign done      = done_q;
    assign out_valid = (state == SHIFT);
    assign out_bit   = word_q[pos[6:0]];

endmodule

// File: verilog/rate_matcher_top.sv
`timescale 1ns/1ps
`include "rm_config.svh"

module rate_matcher_top
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [`RM_WORD_W-1:0] in_word,
    input  logic [1:0]            in_pn,
    input  logic                  in_first,
    input  logic                  start,
    input  rm_pkg::rm_job_t       job,
    output logic                  busy,
    output logic                  done,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic                  out_bit
);
    import rm_pkg::*;

    wb_req_t ld_req;
    wb_rsp_t ld_rsp;
    wb_req_t sel_req;
    wb_rsp_t sel_rsp;
    wb_req_t mem_req;
    wb_rsp_t mem_rsp;

    buffer_loader buffer_loader_i
    (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_word  (in_word),
        .in_pn    (in_pn),
        .in_first (in_first),
        .wb       (ld_req),
        .rsp      (ld_rsp)
    );

    bit_selector bit_selector_i
    (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .job       (job),
        .busy      (busy),
        .done      (done),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_bit   (out_bit),
        .wb        (sel_req),
        .rsp       (sel_rsp)
    );

    buffer_arbiter buffer_arbiter_i
    (
        .clk     (clk),
        .rst     (rst),
        .ld_req  (ld_req),
        .ld_rsp  (ld_rsp),
        .sel_req (sel_req),
        .sel_rsp (sel_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    circular_buffer_mem circular_buffer_mem_i
    (
        .clk (clk),
        .rst (rst),
        .req (mem_req),
        .rsp (mem_rsp)
    );

endmodule

// File: verification/rate_matcher_assert.sv
`timescale 1ns/1ps

module rate_matcher_assert
(
    input logic            clk,
    input logic            rst,
    input rm_pkg::wb_req_t ld_req,
    input rm_pkg::wb_req_t sel_req,
    input rm_pkg::wb_req_t mem_req,
    input rm_pkg::wb_rsp_t mem_rsp,
    input logic            out_valid,
    input logic            out_ready,
    input logic            out_bit
);

    ack_needs_stb: assert property (@(posedge clk) disable iff (!rst)
        mem_rsp.ack |-> mem_req.stb)
        else $error("memory ack without stb");

    // grant is registered, so an idle bus stays idle one more cycle
    no_request_forwarded: assert property (@(posedge clk) disable iff (!rst)
        !(ld_req.cyc || sel_req.cyc) |-> !mem_req.cyc ##1 !mem_req.cyc)
        else $error("arbiter forwards cyc while no master requests");

    stream_holds: assert property (@(posedge clk) disable iff (!rst)
        out_valid && !out_ready |=> out_valid && $stable(out_bit))
        else $error("out_valid or out_bit changed under back-pressure");

endmodule

bind rate_matcher_top rate_matcher_assert rate_matcher_assert_i
(
    .clk       (clk),
    .rst       (rst),
    .ld_req    (ld_req),
    .sel_req   (sel_req),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_bit   (out_bit)
);

// File: verification/rate_matcher_tb.sv
`timescale 1ns/1ps
`include "rm_config.svh"

module rate_matcher_tb;
    import rm_pkg::*;

    localparam int E_SUM  = 700 + 2500 + 700 + 1500 + 3000 + 300;
    localparam int LOADED = 60;                            // words written over the run
    localparam int LIMIT  = 4 * E_SUM + 10 * LOADED;

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    logic                  in_ready;
    logic [`RM_WORD_W-1:0] in_word;
    logic [1:0]            in_pn;
    logic                  in_first;
    logic                  start;
    rm_job_t               job;
    logic                  busy;
    logic                  done;
    logic                  out_valid;
    logic                  out_ready;
    logic                  out_bit;

    logic [`RM_WORD_W-1:0] ref_mem [`RM_NUM_PROC * `RM_PROC_WORDS];  // model of the buffer
    rm_job_t               cur_job;
    rm_job_t               j_trunc;
    logic                  exp_bit;
    int                    exp_e;
    int                    bit_cnt;
    int                    total_bits;
    int                    errors;
    int                    tests;
    int                    cycles;
    bit                    job_active;
    bit                    done_seen;
    bit                    last_seen;                    // e-th bit went out last cycle
    bit                    bp_mode;

    rate_matcher_top rate_matcher_top_i
    (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_word   (in_word),
        .in_pn     (in_pn),
        .in_first  (in_first),
        .start     (start),
        .job       (job),
        .busy      (busy),
        .done      (done),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_bit   (out_bit)
    );

    // expected n-th output bit at position (k0 + n) mod ncb of the process region
    function automatic logic ref_bit_at(input rm_job_t j, input int n);
        int                    coef_bg1 [4];
        int                    coef_bg2 [4];
        int                    k0;
        int                    p;
        logic [`RM_WORD_W-1:0] w;
        coef_bg1 = '{0, 17, 33, 56};
        coef_bg2 = '{0, 13, 25, 43};
        k0 = (j.bg == BG1) ? coef_bg1[j.rv] * int'(j.z) : coef_bg2[j.rv] * int'(j.z);
        p = (k0 + n) % int'(j.ncb);
        w = ref_mem[int'(j.pn) * `RM_PROC_WORDS + p / `RM_WORD_W];
        return w[p % `RM_WORD_W];
    endfunction

    function automatic rm_job_t make_job(input base_graph_e bg, input int z, input int rv,
                                         input int pn, input int ncb, input int e);
        rm_job_t j;
        j.bg  = bg;
        j.z   = z[`RM_Z_W-1:0];
        j.rv  = rv[1:0];
        j.pn  = pn[1:0];
        j.ncb = ncb[`RM_LEN_W-1:0];
        j.e   = e[`RM_LEN_W-1:0];
        return j;
    endfunction

    function automatic logic [`RM_WORD_W-1:0] rand_word();
        logic [`RM_WORD_W-1:0] w;
        for (int k = 0; k < `RM_WORD_W / 32; k++)
        begin
            w[32*k +: 32] = $urandom;
        end
        return w;
    endfunction

    task automatic load_words(input int pn, input int count);
        logic [`RM_WORD_W-1:0] w;
        @(posedge clk);
        #1;
        for (int i = 0; i < count; i++)
        begin
            w = rand_word();
            in_valid = 1'b1;
            in_word  = w;
            in_pn    = pn[1:0];
            in_first = (i == 0);
            ref_mem[pn * `RM_PROC_WORDS + i] = w;
            do
            begin
                @(negedge clk);
            end
            while (!in_ready);                             // taken at the next rising edge
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        in_first = 1'b0;
    endtask

    task automatic run_job(input rm_job_t j, input string name);
        int err_start;
        err_start  = errors;
        cur_job    = j;
        exp_e      = j.e;
        bit_cnt    = 0;
        done_seen  = 1'b0;
        job_active = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b1;
        job   = j;
        @(posedge clk);
        #1;
        start = 1'b0;
        wait (done_seen);
        job_active = 1'b0;
        if (bit_cnt != exp_e)
        begin
            errors++;
            $display("%s: %0d bits arrived before done, expected %0d", name, bit_cnt, exp_e);
        end
        tests++;
        $display("%s: %s, %0d bits", name, (errors == err_start) ? "ok" : "FAIL", bit_cnt);
    endtask

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= LIMIT)
        begin
            $display("timeout: no finish within %0d cycles", LIMIT);
            $display("test failed");
            $finish;
        end
    end

    always @(posedge clk)
    begin
        #1;
        out_ready = bp_mode ? 1'($urandom_range(1, 0)) : 1'b1;
    end

    // outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            if (last_seen && !done)
            begin
                errors++;
                $display("done missing one cycle after bit %0d", bit_cnt);
            end
            if (done && !last_seen)
            begin
                errors++;
                $display("done pulsed after %0d of %0d bits", bit_cnt, exp_e);
            end
            if (done && busy)
            begin
                errors++;
                $display("busy still high while done pulses");
            end
            if (done)
            begin
                done_seen = 1'b1;
            end
            last_seen = 1'b0;
            if (out_valid && out_ready)
            begin
                if (!job_active || bit_cnt >= exp_e)
                begin
                    errors++;
                    $display("bit transferred outside a job or past e = %0d", exp_e);
                end
                else
                begin
                    exp_bit = ref_bit_at(cur_job, bit_cnt);
                    if (out_bit !== exp_bit)
                    begin
                        errors++;
                        $display("Mismatch out_bit at bit %0d: got %h expected %h",
                                 bit_cnt, out_bit, exp_bit);
                    end
                    bit_cnt++;
                    total_bits++;
                    last_seen = (bit_cnt == exp_e);
                end
            end
        end
    end

    initial
    begin
        void'($urandom(32'he028e2f9));
        rst        = 1'b0;
        in_valid   = 1'b0;
        in_word    = '0;
        in_pn      = '0;
        in_first   = 1'b0;
        start      = 1'b0;
        job        = '0;
        out_ready  = 1'b1;
        bp_mode    = 1'b0;
        errors     = 0;
        tests      = 0;
        cycles     = 0;
        total_bits = 0;
        bit_cnt    = 0;
        exp_e      = 0;
        job_active = 1'b0;
        done_seen  = 1'b0;
        last_seen  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;
        @(negedge clk);
        if ({out_valid, busy, done, in_ready} !== 4'b0001)
        begin
            errors++;
            $display("Mismatch {out_valid,busy,done,in_ready} after reset: got %h expected 1",
                     {out_valid, busy, done, in_ready});
        end
        tests++;
        $display("reset state: %s", (errors == 0) ? "ok" : "FAIL");

        load_words(0, 20);
        load_words(1, 20);                                 // old data, overwritten later
        j_trunc = make_job(BG1, 16, 2, 0, 2000, 700);
        run_job(j_trunc, "truncation");
        run_job(make_job(BG2, 10, 3, 0, 1000, 2500), "repetition with wrap");
        bp_mode = 1'b1;
        run_job(j_trunc, "back-pressure");
        bp_mode = 1'b0;

        fork
            load_words(1, 20);
            run_job(make_job(BG1, 20, 1, 0, 2400, 1500), "read during load");
        join
        run_job(make_job(BG2, 12, 0, 1, 2560, 3000), "reloaded process");

        fork
            run_job(make_job(BG1, 8, 0, 0, 1024, 300), "start while busy");
            begin
                wait (job_active && bit_cnt >= 10);
                @(posedge clk);
                #1;
                start = 1'b1;
                job   = make_job(BG2, 4, 1, 1, 512, 50);
                @(posedge clk);
                #1;
                start = 1'b0;
            end
        join
        repeat (20) @(posedge clk);
        if (busy)
        begin
            errors++;
            $display("selector busy again after done, second start was not ignored");
        end

        $display("%0d tests, %0d bits checked, %0d errors", tests, total_bits, errors);
        if (errors == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+verilog
verilog/rm_pkg.sv
verilog/buffer_loader.sv
verilog/buffer_arbiter.sv
verilog/circular_buffer_mem.sv
verilog/bit_selector.sv
verilog/rate_matcher_top.sv
verification/rate_matcher_assert.sv
verification/rate_matcher_tb.sv

// File: Bender.yml
package:
  name: rate_matcher

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rm_pkg.sv
      - verilog/buffer_loader.sv
      - verilog/buffer_arbiter.sv
      - verilog/circular_buffer_mem.sv
      - verilog/bit_selector.sv
      - verilog/rate_matcher_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verification/rate_matcher_assert.sv
      - verification/rate_matcher_tb.sv
